// File: hdl/csi_rx_defs.svh
`ifndef CSI_RX_DEFS_SVH
`define CSI_RX_DEFS_SVH

// number of high-speed data lanes, the merger pairs exactly two
`define CSI_LANES 2

// leader byte that starts every high-speed burst
`define CSI_SYNC_BYTE 8'hB8

// output FIFO depth in items
`define CSI_FIFO_DEPTH 16

// width of the saturating header ECC error counter
`define CSI_ERR_CNT_W 8

`endif

// File: hdl/csi_rx_pkg.sv
package csi_rx_pkg;

  // one lane sample word, bit 0 is the oldest bit on the wire
  typedef logic [7:0] raw_word_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } lane_byte_t;

  // lo is lane 0 and comes first in the packet byte order
  typedef struct packed {
    logic [7:0] hi;
    logic [7:0] lo;
  } lane_pair_t;

  typedef enum logic {
    HEADER = 1'b0,
    DATA   = 1'b1
  } item_kind_t;

  // header items carry the word count in data, data items carry payload
  typedef struct packed {
    item_kind_t  kind;
    logic        last;
    logic [7:0]  data_id;
    logic [15:0] data;
  } csi_item_t;

endpackage

// File: hdl/hs_lane_rx.sv
`timescale 1ns/10ps

`include "csi_rx_defs.svh"

module hs_lane_rx import csi_rx_pkg::*; (
  input  logic       byte_clk_i,
  input  logic       rst_n_i,
  input  logic       hs_enable_i,
  input  raw_word_t  raw_i,
  output lane_byte_t byte_o
);

  logic        en_d1;
  logic        en_d2;
  raw_word_t   raw_q;
  raw_word_t   prev_q;
  logic [15:0] window;
  logic        sync_hit;
  logic [2:0]  sync_pos;
  logic        locked;
  logic [2:0]  offset;
  logic        byte_valid;
  logic [7:0]  byte_data;

  // the enable comes from the low-power side, so it is resynchronized here
  always_ff @(posedge byte_clk_i)
  begin
    if (!rst_n_i)
    begin
      en_d1 <= 1'b0;
      en_d2 <= 1'b0;
    end
    else
    begin
      en_d1 <= hs_enable_i;
      en_d2 <= en_d1;
    end
  end

  always_ff @(posedge byte_clk_i)
  begin
    raw_q  <= raw_i;
    prev_q <= raw_q;
  end

  // older word in the low half keeps the window in wire order
  assign window = {raw_q, prev_q};

  // lowest matching offset wins
  always_comb
  begin
    sync_hit = 1'b0;
    sync_pos = 3'd0;
    for (int k = 7; k >= 0; k--)
    begin
      if (window[k +: 8] == `CSI_SYNC_BYTE)
      begin
        sync_hit = 1'b1;
        sync_pos = 3'(k);
      end
    end
  end

  always_ff @(posedge byte_clk_i)
  begin
    if (!rst_n_i)
    begin
      locked     <= 1'b0;
      offset     <= 3'd0;
      byte_valid <= 1'b0;
    end
    else if (!en_d2)
    begin
      locked     <= 1'b0;
      byte_valid <= 1'b0;
    end
    else if (!locked)
    begin
      // the sync byte itself is not passed on
      byte_valid <= 1'b0;
      if (sync_hit)
      begin
        locked <= 1'b1;
        offset <= sync_pos;
      end
    end
    else
    begin
      byte_valid <= 1'b1;
    end
  end

  always_ff @(posedge byte_clk_i)
  begin
    byte_data <= window[offset +: 8];
  end

  assign byte_o.valid = byte_valid;
  assign byte_o.data  = byte_data;

endmodule

// File: hdl/lane_merger.sv
`timescale 1ns/10ps

`include "csi_rx_defs.svh"

module lane_merger import csi_rx_pkg::*; (
  input  logic       byte_clk_i,
  input  logic       rst_n_i,
  input  lane_byte_t lane0_i,
  input  lane_byte_t lane1_i,
  output lane_pair_t word_o,
  output logic       word_valid_o,
  output logic       burst_end_o
);

  lane_byte_t lane_in [`CSI_LANES];
  logic [7:0] store   [`CSI_LANES][2];
  logic [1:0] cnt     [`CSI_LANES];
  logic [7:0] head    [`CSI_LANES];
  logic       avail   [`CSI_LANES];
  logic       pop     [`CSI_LANES];
  logic       push    [`CSI_LANES];
  logic       wr_idx  [`CSI_LANES];
  logic       pair;
  logic       burst_active;
  logic       burst_done;

  assign lane_in[0] = lane0_i;
  assign lane_in[1] = lane1_i;

  // a lane that locks early parks up to two bytes until the other catches up
  always_comb
  begin
    for (int l = 0; l < `CSI_LANES; l++)
    begin
      avail[l] = (cnt[l] != 2'd0) || lane_in[l].valid;
      head[l]  = (cnt[l] != 2'd0) ? store[l][0] : lane_in[l].data;
    end
    pair = avail[0] && avail[1];
    for (int l = 0; l < `CSI_LANES; l++)
    begin
      pop[l]    = pair && (cnt[l] != 2'd0);
      push[l]   = lane_in[l].valid && !(pair && (cnt[l] == 2'd0)) &&
                  ((cnt[l] != 2'd2) || pop[l]);
      wr_idx[l] = (cnt[l] == 2'd2) || ((cnt[l] == 2'd1) && !pop[l]);
    end
  end

  assign burst_done = burst_active && !lane0_i.valid && !lane1_i.valid;

  always_ff @(posedge byte_clk_i)
  begin
    if (!rst_n_i)
    begin
      burst_active <= 1'b0;
      burst_end_o  <= 1'b0;
      word_valid_o <= 1'b0;
      for (int l = 0; l < `CSI_LANES; l++)
        cnt[l] <= 2'd0;
    end
    else
    begin
      word_valid_o <= pair;
      burst_end_o  <= burst_done;
      if (lane0_i.valid || lane1_i.valid)
        burst_active <= 1'b1;
      else if (burst_done)
        burst_active <= 1'b0;
      for (int l = 0; l < `CSI_LANES; l++)
      begin
        // bytes with no partner left are dropped when the burst closes
        if (burst_done)
          cnt[l] <= 2'd0;
        else
          cnt[l] <= cnt[l] + {1'b0, push[l]} - {1'b0, pop[l]};
      end
    end
  end

  always_ff @(posedge byte_clk_i)
  begin
    word_o.lo <= head[0];
    word_o.hi <= head[1];
    for (int l = 0; l < `CSI_LANES; l++)
    begin
      if (pop[l])
        store[l][0] <= store[l][1];
      if (push[l])
        store[l][wr_idx[l]] <= lane_in[l].data;
    end
  end

endmodule

// File: hdl/packet_header_decoder.sv
`timescale 1ns/10ps

`include "csi_rx_defs.svh"

module packet_header_decoder import csi_rx_pkg::*; (
  input  logic                      byte_clk_i,
  input  logic                      rst_n_i,
  input  lane_pair_t                word_i,
  input  logic                      word_valid_i,
  input  logic                      burst_end_i,
  output csi_item_t                 item_o,
  output logic                      push_o,
  output logic [`CSI_ERR_CNT_W-1:0] ecc_err_count_o
);

  typedef enum logic [2:0] {
    ST_HDR0,
    ST_HDR1,
    ST_DATA,
    ST_CRC,
    ST_SKIP
  } state_t;

  // parity masks of the CSI-2 header Hamming code, P0 first
  localparam logic [23:0] ECC_MASK [6] = '{
    24'hF12CB7,
    24'hF2555B,
    24'h749A6D,
    24'hB8E38E,
    24'hDF03F0,
    24'hEFFC00
  };

  state_t      state;
  logic [7:0]  data_id_q;
  logic [7:0]  wc_lsb_q;
  logic [15:0] wc;
  logic [14:0] words_left;
  logic        ecc_ok;
  logic        short_pkt;
  logic        hdr_last;

  function automatic logic [5:0] calc_ecc(input logic [23:0] d);
    logic [5:0] p;
    for (int i = 0; i < 6; i++)
      p[i] = ^(d & ECC_MASK[i]);
    return p;
  endfunction

  // header byte order is data ID, WC low, WC high, ECC
  assign wc        = {word_i.lo, wc_lsb_q};
  assign ecc_ok    = word_i.hi == {2'b00, calc_ecc({wc, data_id_q})};
  assign short_pkt = data_id_q < 8'h10;
  assign hdr_last  = short_pkt || (wc[15:1] == 15'd0);

  always_ff @(posedge byte_clk_i)
  begin
    if (!rst_n_i)
    begin
      state           <= ST_HDR0;
      push_o          <= 1'b0;
      words_left      <= 15'd0;
      ecc_err_count_o <= '0;
    end
    else
    begin
      push_o <= 1'b0;
      if (burst_end_i)
        state <= ST_HDR0;
      else if (word_valid_i)
      begin
        case (state)
          ST_HDR0:
            state <= ST_HDR1;
          ST_HDR1:
          begin
            if (ecc_ok)
            begin
              push_o     <= 1'b1;
              words_left <= wc[15:1];
              if (short_pkt)
                state <= ST_SKIP;
              else if (wc[15:1] == 15'd0)
                state <= ST_CRC;
              else
                state <= ST_DATA;
            end
            else
            begin
              if (ecc_err_count_o != '1)
                ecc_err_count_o <= ecc_err_count_o + 1'b1;
              state <= ST_SKIP;
            end
          end
          ST_DATA:
          begin
            push_o     <= 1'b1;
            words_left <= words_left - 1'b1;
            if (words_left == 15'd1)
              state <= ST_CRC;
          end
          // the CRC word is consumed here and not checked
          ST_CRC:
            state <= ST_SKIP;
          default:
            state <= ST_SKIP;
        endcase
      end
    end
  end

  always_ff @(posedge byte_clk_i)
  begin
    if (word_valid_i && (state == ST_HDR0))
    begin
      data_id_q <= word_i.lo;
      wc_lsb_q  <= word_i.hi;
    end
    item_o.data_id <= data_id_q;
    if (state == ST_HDR1)
    begin
      item_o.kind <= HEADER;
      item_o.last <= hdr_last;
      item_o.data <= wc;
    end
    else
    begin
      item_o.kind <= DATA;
      item_o.last <= words_left == 15'd1;
      item_o.data <= word_i;
    end
  end

endmodule

// File: hdl/stream_fifo.sv
`timescale 1ns/10ps

`include "csi_rx_defs.svh"

module stream_fifo import csi_rx_pkg::*; #(
  parameter int DEPTH = `CSI_FIFO_DEPTH
)(
  input  logic      byte_clk_i,
  input  logic      rst_n_i,
  input  csi_item_t item_i,
  input  logic      push_i,
  output csi_item_t item_o,
  output logic      valid_o,
  input  logic      ready_i,
  output logic      overflow_o
);

  localparam int AW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH + 1);

  csi_item_t     mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          full;
  logic          wr_en;
  logic          rd_en;

  // pointers wrap at DEPTH so any depth works, not only powers of two
  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
    return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full    = count == CW'(DEPTH);
  assign valid_o = count != '0;
  assign item_o  = mem[rd_ptr];
  assign wr_en   = push_i && !full;
  assign rd_en   = valid_o && ready_i;

  always_ff @(posedge byte_clk_i)
  begin
    if (wr_en)
      mem[wr_ptr] <= item_i;
  end

  always_ff @(posedge byte_clk_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      overflow_o <= 1'b0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= next_ptr(wr_ptr);
      if (rd_en)
        rd_ptr <= next_ptr(rd_ptr);
      if (wr_en && !rd_en)
        count <= count + 1'b1;
      else if (!wr_en && rd_en)
        count <= count - 1'b1;
      // a push while full is lost, the flag stays up until reset
      if (push_i && full)
        overflow_o <= 1'b1;
    end
  end

endmodule

// File: hdl/csi_rx_top.sv
`timescale 1ns/10ps

`include "csi_rx_defs.svh"

module csi_rx_top import csi_rx_pkg::*; (
  input  logic                      byte_clk_i,
  input  logic                      rst_n_i,
  input  logic [`CSI_LANES-1:0]     lane_enable_i,
  input  raw_word_t                 lane0_raw_i,
  input  raw_word_t                 lane1_raw_i,
  output csi_item_t                 m_item_o,
  output logic                      m_valid_o,
  input  logic                      m_ready_i,
  output logic [`CSI_ERR_CNT_W-1:0] ecc_err_count_o,
  output logic                      overflow_o
);

  lane_byte_t lane0_byte;
  lane_byte_t lane1_byte;
  lane_pair_t pair_word;
  logic       pair_valid;
  logic       burst_end;
  csi_item_t  item;
  logic       item_push;

  hs_lane_rx lane0_rx (
    .byte_clk_i  ( byte_clk_i       ),
    .rst_n_i     ( rst_n_i          ),
    .hs_enable_i ( lane_enable_i[0] ),
    .raw_i       ( lane0_raw_i      ),
    .byte_o      ( lane0_byte       )
  );

  hs_lane_rx lane1_rx (
    .byte_clk_i  ( byte_clk_i       ),
    .rst_n_i     ( rst_n_i          ),
    .hs_enable_i ( lane_enable_i[1] ),
    .raw_i       ( lane1_raw_i      ),
    .byte_o      ( lane1_byte       )
  );

  lane_merger merger (
    .byte_clk_i   ( byte_clk_i ),
    .rst_n_i      ( rst_n_i    ),
    .lane0_i      ( lane0_byte ),
    .lane1_i      ( lane1_byte ),
    .word_o       ( pair_word  ),
    .word_valid_o ( pair_valid ),
    .burst_end_o  ( burst_end  )
  );

  packet_header_decoder decoder (
    .byte_clk_i      ( byte_clk_i      ),
    .rst_n_i         ( rst_n_i         ),
    .word_i          ( pair_word       ),
    .word_valid_i    ( pair_valid      ),
    .burst_end_i     ( burst_end       ),
    .item_o          ( item            ),
    .push_o          ( item_push       ),
    .ecc_err_count_o ( ecc_err_count_o )
  );

  stream_fifo #(
    .DEPTH      ( `CSI_FIFO_DEPTH )
  ) out_fifo (
    .byte_clk_i ( byte_clk_i      ),
    .rst_n_i    ( rst_n_i         ),
    .item_i     ( item            ),
    .push_i     ( item_push       ),
    .item_o     ( m_item_o        ),
    .valid_o    ( m_valid_o       ),
    .ready_i    ( m_ready_i       ),
    .overflow_o ( overflow_o      )
  );

endmodule

// File: testbench/tb_csi_rx.sv
`timescale 1ns/10ps

`include "csi_rx_defs.svh"

module tb_csi_rx import csi_rx_pkg::*; ();

  typedef struct packed {
    logic [1:0] en;
    raw_word_t  raw0;
    raw_word_t  raw1;
  } stim_t;

  logic                      byte_clk_i;
  logic                      rst_n_i;
  logic [`CSI_LANES-1:0]     lane_enable_i;
  raw_word_t                 lane0_raw_i;
  raw_word_t                 lane1_raw_i;
  csi_item_t                 m_item_o;
  logic                      m_valid_o;
  logic                      m_ready_i;
  logic [`CSI_ERR_CNT_W-1:0] ecc_err_count_o;
  logic                      overflow_o;

  stim_t       stim_q [$];
  csi_item_t   exp_q [$];
  csi_item_t   exp_item;
  stim_t       cur_stim;
  int          exp_err_count = 0;
  int          value_errors = 0;
  int          other_errors = 0;
  int          items_checked = 0;
  int          cycle_count = 0;
  int          cycle_limit = 100000;
  logic [15:0] lfsr_state = 16'd18;
  logic        burst_seen = 1'b0;

  csi_rx_top uut (
    .byte_clk_i      ( byte_clk_i      ),
    .rst_n_i         ( rst_n_i         ),
    .lane_enable_i   ( lane_enable_i   ),
    .lane0_raw_i     ( lane0_raw_i     ),
    .lane1_raw_i     ( lane1_raw_i     ),
    .m_item_o        ( m_item_o        ),
    .m_valid_o       ( m_valid_o       ),
    .m_ready_i       ( m_ready_i       ),
    .ecc_err_count_o ( ecc_err_count_o ),
    .overflow_o      ( overflow_o      )
  );

  initial
  begin
    byte_clk_i = 1'b0;
  end

  always #50 byte_clk_i = ~byte_clk_i;

  // taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic check_field(input string name, input logic [15:0] exp,
                             input logic [15:0] got);
    if (got !== exp)
    begin
      $display("FAILED at %0t ns: %s expected %h got %h", $time, name, exp, got);
      value_errors++;
    end
  endtask

  task automatic load_trace();
    int        fd;
    string     line;
    byte       tag;
    int        a;
    int        b;
    int        c;
    int        d;
    stim_t     st;
    csi_item_t it;
    fd = $fopen("testbench/csi_rx_trace.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the trace file testbench/csi_rx_trace.txt");
      other_errors++;
      return;
    end
    while (!$feof(fd))
    begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2)
        continue;
      tag = line.getc(0);
      if (tag == "s")
      begin
        void'($sscanf(line, "%c %d %h %h %h", tag, a, b, c, d));
        st.en   = b[1:0];
        st.raw0 = c[7:0];
        st.raw1 = d[7:0];
        repeat (a)
          stim_q.push_back(st);
      end
      else if (tag == "e")
      begin
        void'($sscanf(line, "%c %h %h %h %h", tag, a, b, c, d));
        it.kind    = item_kind_t'(a[0]);
        it.last    = b[0];
        it.data_id = c[7:0];
        it.data    = d[15:0];
        exp_q.push_back(it);
      end
      else if (tag == "c")
      begin
        void'($sscanf(line, "%c %d", tag, exp_err_count));
      end
    end
    $fclose(fd);
  endtask

  // consumer back-pressure, one LFSR step per ready bit
  always @(negedge byte_clk_i)
  begin
    lfsr_state = lfsr_next(lfsr_state);
    m_ready_i  = lfsr_state[0];
  end

  always @(posedge byte_clk_i)
  begin
    if (rst_n_i && m_valid_o && m_ready_i)
    begin
      if (exp_q.size() == 0)
      begin
        $display("an item arrived at %0t ns when no more items were expected", $time);
        other_errors++;
      end
      else
      begin
        exp_item = exp_q.pop_front();
        check_field("m_item_o.kind", 16'(exp_item.kind), 16'(m_item_o.kind));
        check_field("m_item_o.last", 16'(exp_item.last), 16'(m_item_o.last));
        check_field("m_item_o.data_id", 16'(exp_item.data_id), 16'(m_item_o.data_id));
        check_field("m_item_o.data", exp_item.data, m_item_o.data);
        items_checked++;
      end
    end
  end

  always @(posedge byte_clk_i)
  begin
    cycle_count++;
    if (cycle_count > cycle_limit)
    begin
      $display("timeout after %0d cycles with %0d items still missing",
               cycle_count, exp_q.size());
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial
  begin
    rst_n_i       = 1'b0;
    lane_enable_i = '0;
    lane0_raw_i   = '0;
    lane1_raw_i   = '0;
    m_ready_i     = 1'b0;
    load_trace();
    cycle_limit = 2 * stim_q.size() + 200;

    repeat (10)
    begin
      @(negedge byte_clk_i);
      check_field("m_valid_o", 16'(1'b0), 16'(m_valid_o));
      check_field("overflow_o", 16'(1'b0), 16'(overflow_o));
    end
    rst_n_i = 1'b1;

    while (stim_q.size() != 0)
    begin
      @(negedge byte_clk_i);
      cur_stim = stim_q.pop_front();
      // nothing may come out before the first burst
      if (!burst_seen)
      begin
        check_field("m_valid_o", 16'(1'b0), 16'(m_valid_o));
        check_field("overflow_o", 16'(1'b0), 16'(overflow_o));
      end
      if (cur_stim.en != 2'b00)
        burst_seen = 1'b1;
      lane_enable_i = cur_stim.en;
      lane0_raw_i   = cur_stim.raw0;
      lane1_raw_i   = cur_stim.raw1;
    end
    @(negedge byte_clk_i);
    lane_enable_i = '0;
    lane0_raw_i   = '0;
    lane1_raw_i   = '0;

    while (exp_q.size() != 0)
      @(negedge byte_clk_i);
    repeat (20)
      @(negedge byte_clk_i);

    check_field("ecc_err_count_o", 16'(exp_err_count), 16'(ecc_err_count_o));
    check_field("overflow_o", 16'(1'b0), 16'(overflow_o));

    $display("%0d items compared, %0d value errors, %0d other errors",
             items_checked, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
    begin
      $display("TESTBENCH PASSED");
    end
    else
    begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: testbench/csi_rx_trace.txt
# s <cycles> <lane enables hex> <lane0 raw hex> <lane1 raw hex>  stimulus, one word per cycle
# e <kind> <last> <data id hex> <data hex>  expected item; c <count>  expected ECC errors
s 5 0 00 00
s 1 3 c0 00
s 1 3 05 37
s 1 3 00 40
s 1 3 00 03
s 8 0 00 00
s 1 3 b8 b8
s 1 3 2a 08
s 1 3 00 35
s 1 3 11 22
s 1 3 33 44
s 1 3 55 66
s 1 3 77 88
s 1 3 c1 c2
s 1 3 00 00
s 8 0 00 00
s 1 1 b8 00
s 1 3 2b b8
s 1 3 00 04
s 1 3 a1 34
s 1 3 b1 a2
s 1 3 e1 b2
s 1 3 00 e2
s 1 2 00 00
s 8 0 00 00
s 1 3 b8 b8
s 1 3 2a 08
s 1 3 00 34
s 1 3 11 22
s 1 3 00 00
s 8 0 00 00
s 1 3 b8 b8
s 1 3 01 02
s 1 3 00 1b
s 1 3 00 00
s 10 0 00 00
e 0 1 00 0001
e 0 0 2a 0008
e 1 0 2a 2211
e 1 0 2a 4433
e 1 0 2a 6655
e 1 1 2a 8877
e 0 0 2b 0004
e 1 0 2b a2a1
e 1 1 2b b2b1
e 0 1 01 0002
c 1

// File: tb.f
+incdir+hdl
hdl/csi_rx_pkg.sv
hdl/hs_lane_rx.sv
hdl/lane_merger.sv
hdl/packet_header_decoder.sv
hdl/stream_fifo.sv
hdl/csi_rx_top.sv
testbench/tb_csi_rx.sv
